// File: src/mem_defines.svh
`ifndef MEM_DEFINES_SVH
`define MEM_DEFINES_SVH

//**************************************************************************
// datapath geometry
//**************************************************************************

// data and address width
`define MEM_DATA_W 32

// byte lanes per word
`define MEM_LANES  4

//**************************************************************************
// exception causes
//**************************************************************************

// mcause codes with the interrupt bit clear
`define TRAP_LOAD_MISALIGNED  4
`define TRAP_STORE_MISALIGNED 6

`endif

// File: src/mem_pkg.sv
`include "mem_defines.svh"

package mem_pkg;

  // data, address, pc and mcause values
  typedef logic [`MEM_DATA_W-1:0] word_t;

  // one lane datum
  typedef logic [7:0] byte_t;

  // one strobe bit per lane
  typedef logic [`MEM_LANES-1:0] strb_t;

  // register file index
  typedef logic [4:0] reg_addr_t;

  // one-hot access size
  // bit 4 word, 3 half unsigned, 2 half, 1 byte unsigned, 0 byte
  typedef logic [4:0] size_onehot_t;

  // byte count code
  // 0 one byte, 1 two bytes, 2 four bytes
  typedef logic [1:0] lane_size_t;

  // byte offset inside a word
  typedef logic [1:0] lane_ofs_t;

endpackage

// File: src/lane_if.sv
`timescale 1ns/1ps
`include "mem_defines.svh"

interface lane_if;
  import mem_pkg::*;

  // access geometry, common to all lanes
  lane_ofs_t  ofs;
  lane_size_t size;
  logic       active;
  word_t      store_word;
  word_t      load_word;

  // per-lane results
  byte_t      store_byte [`MEM_LANES];
  logic       strb       [`MEM_LANES];
  byte_t      load_byte  [`MEM_LANES];

  modport ctrl (
    output ofs, size, active, store_word, load_word
  );

  modport lane (
    input  ofs, size, active, store_word, load_word,
    output store_byte, strb, load_byte
  );

  modport drain (
    input store_byte, strb, load_byte, ofs, size
  );

endinterface

// File: src/mem_access_ctrl.sv
`timescale 1ns/1ps

module mem_access_ctrl (
  input  logic                  clk_i,
  input  logic                  rst_n_i,
  input  mem_pkg::word_t        addr_i,
  input  mem_pkg::word_t        store_data_i,
  input  mem_pkg::word_t        mem_rdata_i,
  input  logic                  is_mem_read_i,
  input  logic                  is_mem_write_i,
  input  mem_pkg::size_onehot_t size_i,
  input  logic                  mem_done_i,
  output mem_pkg::word_t        mem_addr_o,
  output logic                  mem_wen_o,
  output logic                  mem_req_o,
  output logic                  mem_valid_o,
  output logic                  misaligned_load_o,
  output logic                  misaligned_store_o,
  lane_if.ctrl                  lanes
);
  import mem_pkg::*;

  lane_ofs_t  ofs;
  lane_size_t byte_cnt;
  logic       access;
  logic       is_half;
  logic       is_word;
  logic       misaligned;
  logic       start_cond;
  logic       start_cond_q;

  //**************************************************************************
  // size and alignment decode
  //**************************************************************************

  assign ofs     = addr_i[1:0];
  assign access  = is_mem_read_i | is_mem_write_i;
  assign is_word = size_i[4];
  assign is_half = size_i[3] | size_i[2];

  // one-hot size to byte count code
  always_comb
  begin
    if (is_word)
      byte_cnt = 2'd2;
    else if (is_half)
      byte_cnt = 2'd1;
    else
      byte_cnt = 2'd0;
  end

  // bytes never misalign
  assign misaligned = (is_half & addr_i[0]) | (is_word & (ofs != 2'd0));

  assign misaligned_load_o  = is_mem_read_i & misaligned;
  assign misaligned_store_o = is_mem_write_i & misaligned;

  //**************************************************************************
  // memory port
  //**************************************************************************

  assign mem_req_o  = access & ~misaligned;
  assign mem_wen_o  = is_mem_write_i;
  assign mem_addr_o = addr_i;

  // start pulse on the rising edge of an outstanding request
  assign start_cond = mem_req_o & ~mem_done_i;

  always_ff @(posedge clk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
      start_cond_q <= 1'b0;
    else
      start_cond_q <= start_cond;
  end

  assign mem_valid_o = start_cond & ~start_cond_q;

  //**************************************************************************
  // lane geometry
  //**************************************************************************

  assign lanes.ofs        = ofs;
  assign lanes.size       = byte_cnt;
  assign lanes.active     = access;
  assign lanes.store_word = store_data_i;
  assign lanes.load_word  = mem_rdata_i;

endmodule

// File: src/mem_byte_lane.sv
`timescale 1ns/1ps

module mem_byte_lane #(
  parameter int unsigned LANE = 0
) (
  lane_if.lane lanes
);
  import mem_pkg::*;

  lane_ofs_t  lane_idx;
  lane_ofs_t  store_sel;
  lane_ofs_t  load_sel;
  logic [2:0] lane_pos;
  logic [2:0] span_end;
  logic       in_span;
  byte_t      store_byte;
  byte_t      load_byte;

  assign lane_idx = lane_ofs_t'(LANE);
  assign lane_pos = 3'(LANE);

  // store side rotates data up by the offset
  assign store_sel  = lane_idx - lanes.ofs;
  assign store_byte = lanes.store_word[{store_sel, 3'b000} +: 8];

  // first lane past the access
  assign span_end = {1'b0, lanes.ofs} + (3'd1 << lanes.size);
  assign in_span  = (lane_pos >= {1'b0, lanes.ofs}) && (lane_pos < span_end);

  // load side rotates down so the addressed byte lands in lane 0
  assign load_sel  = lanes.ofs + lane_idx;
  assign load_byte = lanes.load_word[{load_sel, 3'b000} +: 8];

  assign lanes.store_byte[LANE] = store_byte;
  assign lanes.strb[LANE]       = lanes.active & in_span;
  assign lanes.load_byte[LANE]  = load_byte;

endmodule

// File: src/mem_writeback_mux.sv
`timescale 1ns/1ps
`include "mem_defines.svh"

module mem_writeback_mux (
  lane_if.drain                 lanes,
  input  mem_pkg::word_t        pc_i,
  input  mem_pkg::word_t        pc_plus_4_i,
  input  mem_pkg::word_t        alu_result_i,
  input  mem_pkg::size_onehot_t size_i,
  input  logic                  is_mem_read_i,
  input  logic                  is_mem_write_i,
  input  logic                  valid_i,
  input  logic                  is_rd_write_i,
  input  mem_pkg::reg_addr_t    rd_addr_i,
  input  logic                  is_jump_i,
  input  logic                  is_branch_i,
  input  logic                  branch_predict_i,
  input  logic                  jump_taken_i,
  input  logic                  trap_valid_i,
  input  mem_pkg::word_t        trap_pc_i,
  input  mem_pkg::word_t        trap_mcause_i,
  input  logic                  misaligned_load_i,
  input  logic                  misaligned_store_i,
  output mem_pkg::word_t        mem_wdata_o,
  output mem_pkg::strb_t        mem_strb_o,
  output mem_pkg::word_t        rd_wdata_o,
  output logic                  d_valid_o,
  output logic                  d_is_rd_write_o,
  output mem_pkg::reg_addr_t    d_rd_addr_o,
  output mem_pkg::word_t        d_pc_plus_4_o,
  output logic                  d_trap_valid_o,
  output mem_pkg::word_t        d_trap_pc_o,
  output mem_pkg::word_t        d_trap_mcause_o,
  output logic                  btaken_mispredict_o,
  output logic                  bntaken_mispredict_o,
  output logic                  branch_mispredict_o
);
  import mem_pkg::*;

  word_t store_word;
  word_t load_word;
  word_t load_data;
  strb_t strb;
  logic  sign_ext;

  //**************************************************************************
  // lane assembly
  //**************************************************************************

  always_comb
  begin
    for (int i = 0; i < `MEM_LANES; i++)
    begin
      store_word[8*i +: 8] = lanes.store_byte[i];
      load_word[8*i +: 8]  = lanes.load_byte[i];
      strb[i]              = lanes.strb[i];
    end
  end

  // store data only on writes
  assign mem_wdata_o = is_mem_write_i ? store_word : '0;
  assign mem_strb_o  = strb;

  // unsigned variants are hu and bu
  assign sign_ext = ~(size_i[3] | size_i[1]);

  always_comb
  begin
    case (lanes.size)
      2'd0:    load_data = {{24{sign_ext & load_word[7]}}, load_word[7:0]};
      2'd1:    load_data = {{16{sign_ext & load_word[15]}}, load_word[15:0]};
      default: load_data = load_word;
    endcase
  end

  //**************************************************************************
  // register writeback
  //**************************************************************************

  always_comb
  begin
    if (is_jump_i)
      rd_wdata_o = pc_plus_4_i;
    else if (is_mem_read_i)
      rd_wdata_o = load_data;
    else
      rd_wdata_o = alu_result_i;
  end

  assign d_valid_o       = valid_i;
  assign d_is_rd_write_o = is_rd_write_i & ~misaligned_load_i;
  assign d_rd_addr_o     = rd_addr_i;
  assign d_pc_plus_4_o   = pc_plus_4_i;

  // older trap from upstream wins over local ones
  always_comb
  begin
    d_trap_valid_o  = 1'b1;
    d_trap_pc_o     = pc_i;
    d_trap_mcause_o = '0;
    if (trap_valid_i)
    begin
      d_trap_pc_o     = trap_pc_i;
      d_trap_mcause_o = trap_mcause_i;
    end
    else if (misaligned_store_i)
      d_trap_mcause_o = word_t'(`TRAP_STORE_MISALIGNED);
    else if (misaligned_load_i)
      d_trap_mcause_o = word_t'(`TRAP_LOAD_MISALIGNED);
    else
    begin
      d_trap_valid_o = 1'b0;
      d_trap_pc_o    = '0;
    end
  end

  // branch resolution vs prediction
  assign btaken_mispredict_o  = is_branch_i & branch_predict_i & ~jump_taken_i;
  assign bntaken_mispredict_o = is_branch_i & ~branch_predict_i & jump_taken_i;
  assign branch_mispredict_o  = btaken_mispredict_o | bntaken_mispredict_o;

endmodule

// File: src/mem_stage.sv
`timescale 1ns/1ps
`include "mem_defines.svh"

module mem_stage (
  input  logic                  clk_i,
  input  logic                  rst_n_i,
  // from the execute pipeline register
  input  mem_pkg::word_t        mem_q_pc_i,
  input  mem_pkg::word_t        mem_q_pc_plus_4_i,
  input  mem_pkg::word_t        mem_q_alu_result_i,
  input  mem_pkg::word_t        mem_q_store_wdata_i,
  input  logic                  mem_q_is_mem_read_i,
  input  logic                  mem_q_is_mem_write_i,
  input  mem_pkg::size_onehot_t mem_q_size_i,
  input  logic                  mem_q_valid_i,
  input  logic                  mem_q_is_rd_write_i,
  input  mem_pkg::reg_addr_t    mem_q_rd_addr_i,
  input  logic                  mem_q_is_jump_i,
  input  logic                  mem_q_is_branch_i,
  input  logic                  mem_q_branch_predict_i,
  input  logic                  mem_q_jump_taken_i,
  input  logic                  mem_q_trap_valid_i,
  input  mem_pkg::word_t        mem_q_trap_pc_i,
  input  mem_pkg::word_t        mem_q_trap_mcause_i,
  // data memory
  input  mem_pkg::word_t        mem_rdata_i,
  input  logic                  mem_done_i,
  output mem_pkg::word_t        mem_addr_o,
  output mem_pkg::word_t        mem_wdata_o,
  output mem_pkg::strb_t        mem_strb_o,
  output logic                  mem_wen_o,
  output logic                  mem_req_o,
  output logic                  mem_valid_o,
  // to writeback
  output logic                  mem_d_valid_o,
  output logic                  mem_d_is_rd_write_o,
  output mem_pkg::reg_addr_t    mem_d_rd_addr_o,
  output mem_pkg::word_t        mem_d_rd_wdata_o,
  output mem_pkg::word_t        mem_d_pc_plus_4_o,
  output logic                  mem_d_trap_valid_o,
  output mem_pkg::word_t        mem_d_trap_pc_o,
  output mem_pkg::word_t        mem_d_trap_mcause_o,
  output logic                  mem_btaken_mispredict_o,
  output logic                  mem_bntaken_mispredict_o,
  output logic                  mem_branch_mispredict_o
);

  logic misaligned_load;
  logic misaligned_store;

  lane_if lanes ();

  mem_access_ctrl u_access_ctrl (
    .clk_i              (clk_i),
    .rst_n_i            (rst_n_i),
    .addr_i             (mem_q_alu_result_i),
    .store_data_i       (mem_q_store_wdata_i),
    .mem_rdata_i        (mem_rdata_i),
    .is_mem_read_i      (mem_q_is_mem_read_i),
    .is_mem_write_i     (mem_q_is_mem_write_i),
    .size_i             (mem_q_size_i),
    .mem_done_i         (mem_done_i),
    .mem_addr_o         (mem_addr_o),
    .mem_wen_o          (mem_wen_o),
    .mem_req_o          (mem_req_o),
    .mem_valid_o        (mem_valid_o),
    .misaligned_load_o  (misaligned_load),
    .misaligned_store_o (misaligned_store),
    .lanes              (lanes)
  );

  for (genvar i = 0; i < `MEM_LANES; i++)
  begin : g_lane
    mem_byte_lane #(
      .LANE (i)
    ) u_byte_lane (
      .lanes (lanes)
    );
  end

  mem_writeback_mux u_writeback_mux (
    .lanes                (lanes),
    .pc_i                 (mem_q_pc_i),
    .pc_plus_4_i          (mem_q_pc_plus_4_i),
    .alu_result_i         (mem_q_alu_result_i),
    .size_i               (mem_q_size_i),
    .is_mem_read_i        (mem_q_is_mem_read_i),
    .is_mem_write_i       (mem_q_is_mem_write_i),
    .valid_i              (mem_q_valid_i),
    .is_rd_write_i        (mem_q_is_rd_write_i),
    .rd_addr_i            (mem_q_rd_addr_i),
    .is_jump_i            (mem_q_is_jump_i),
    .is_branch_i          (mem_q_is_branch_i),
    .branch_predict_i     (mem_q_branch_predict_i),
    .jump_taken_i         (mem_q_jump_taken_i),
    .trap_valid_i         (mem_q_trap_valid_i),
    .trap_pc_i            (mem_q_trap_pc_i),
    .trap_mcause_i        (mem_q_trap_mcause_i),
    .misaligned_load_i    (misaligned_load),
    .misaligned_store_i   (misaligned_store),
    .mem_wdata_o          (mem_wdata_o),
    .mem_strb_o           (mem_strb_o),
    .rd_wdata_o           (mem_d_rd_wdata_o),
    .d_valid_o            (mem_d_valid_o),
    .d_is_rd_write_o      (mem_d_is_rd_write_o),
    .d_rd_addr_o          (mem_d_rd_addr_o),
    .d_pc_plus_4_o        (mem_d_pc_plus_4_o),
    .d_trap_valid_o       (mem_d_trap_valid_o),
    .d_trap_pc_o          (mem_d_trap_pc_o),
    .d_trap_mcause_o      (mem_d_trap_mcause_o),
    .btaken_mispredict_o  (mem_btaken_mispredict_o),
    .bntaken_mispredict_o (mem_bntaken_mispredict_o),
    .branch_mispredict_o  (mem_branch_mispredict_o)
  );

endmodule

// File: tests/mem_stage_checker.sv
`timescale 1ns/1ps

module mem_stage_checker (
  input logic clk_i,
  input logic rst_n_i,
  input logic mem_req_i,
  input logic mem_valid_i,
  input logic btaken_mispredict_i,
  input logic bntaken_mispredict_i,
  input logic trap_valid_i,
  input logic q_trap_valid_i
);

  int unsigned fail_cnt = 0;

  // start pulse only with a live request
  valid_needs_req : assert property (@(posedge clk_i) disable iff (!rst_n_i)
    mem_valid_i |-> mem_req_i)
  else
  begin
    $error("mem_valid_o high while mem_req_o is low");
    fail_cnt++;
  end

  valid_one_cycle : assert property (@(posedge clk_i) disable iff (!rst_n_i)
    mem_valid_i |=> !mem_valid_i)
  else
  begin
    $error("mem_valid_o high for two cycles in a row");
    fail_cnt++;
  end

  mispredict_onehot : assert property (@(posedge clk_i) disable iff (!rst_n_i)
    !(btaken_mispredict_i && bntaken_mispredict_i))
  else
  begin
    $error("both mispredict flags high");
    fail_cnt++;
  end

  // local trap means a misaligned access, which never reaches memory
  local_trap_no_req : assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (trap_valid_i && !q_trap_valid_i) |-> !mem_req_i)
  else
  begin
    $error("misalignment trap with mem_req_o high");
    fail_cnt++;
  end

endmodule

bind mem_stage mem_stage_checker u_checker (
  .clk_i                (clk_i),
  .rst_n_i              (rst_n_i),
  .mem_req_i            (mem_req_o),
  .mem_valid_i          (mem_valid_o),
  .btaken_mispredict_i  (mem_btaken_mispredict_o),
  .bntaken_mispredict_i (mem_bntaken_mispredict_o),
  .trap_valid_i         (mem_d_trap_valid_o),
  .q_trap_valid_i       (mem_q_trap_valid_i)
);

// File: tests/mem_stage_tb.sv
`timescale 1ns/1ps
`include "mem_defines.svh"

module mem_stage_tb;
  import mem_pkg::*;

  localparam size_onehot_t SZ_B  = 5'b00001;
  localparam size_onehot_t SZ_BU = 5'b00010;
  localparam size_onehot_t SZ_H  = 5'b00100;
  localparam size_onehot_t SZ_HU = 5'b01000;
  localparam size_onehot_t SZ_W  = 5'b10000;
  localparam int N_ENTRIES = 24;

  // ctl bits from high to low are read, write, jump, branch, predict, taken, trap in
  // cls 0 no trap, 1 misaligned trap, 2 incoming trap
  typedef struct {
    word_t        addr;
    size_onehot_t size;
    logic [6:0]   ctl;
    logic [1:0]   cls;
  } entry_t;

  entry_t stim [N_ENTRIES];

  logic clk_i;
  logic rst_n_i;
  word_t mem_q_pc_i, mem_q_pc_plus_4_i, mem_q_alu_result_i, mem_q_store_wdata_i;
  word_t mem_q_trap_pc_i, mem_q_trap_mcause_i, mem_rdata_i;
  size_onehot_t mem_q_size_i;
  reg_addr_t mem_q_rd_addr_i;
  logic mem_q_is_mem_read_i, mem_q_is_mem_write_i, mem_q_valid_i, mem_q_is_rd_write_i;
  logic mem_q_is_jump_i, mem_q_is_branch_i, mem_q_branch_predict_i, mem_q_jump_taken_i;
  logic mem_q_trap_valid_i, mem_done_i;

  word_t mem_addr_o, mem_wdata_o, mem_d_rd_wdata_o, mem_d_pc_plus_4_o;
  word_t mem_d_trap_pc_o, mem_d_trap_mcause_o;
  strb_t mem_strb_o;
  reg_addr_t mem_d_rd_addr_o;
  logic mem_wen_o, mem_req_o, mem_valid_o, mem_d_valid_o, mem_d_is_rd_write_o;
  logic mem_d_trap_valid_o, mem_btaken_mispredict_o, mem_bntaken_mispredict_o;
  logic mem_branch_mispredict_o;

  // reference model results
  word_t exp_wdata, exp_rd_wdata, exp_trap_pc, exp_trap_mcause;
  strb_t exp_strb;
  logic  exp_req, exp_rd_write, exp_trap_valid, exp_bt, exp_bnt;

  mem_stage u_mem_stage (.*);

  initial
  begin
    clk_i = 1'b0;
    forever #5 clk_i = ~clk_i;
  end

  task automatic stop_with_failure(input string why);
    $display("%s", why);
    $display("STATUS: FAIL");
    $fatal(1, "simulation stopped");
  endtask

  task automatic check_value(input string name, input word_t got, input word_t exp);
    if (got !== exp)
    begin
      $display("error at %0d ns: %s is %h, expected %h", $time, name, got, exp);
      stop_with_failure("output does not match the expected value");
    end
  endtask

  task automatic drive_idle();
    mem_q_pc_i          = '0;
    mem_q_pc_plus_4_i   = 32'd4;
    mem_q_alu_result_i  = '0;
    mem_q_store_wdata_i = '0;
    mem_q_trap_pc_i     = '0;
    mem_q_trap_mcause_i = '0;
    mem_rdata_i         = '0;
    mem_q_size_i        = '0;
    mem_q_rd_addr_i     = '0;
    {mem_q_is_mem_read_i, mem_q_is_mem_write_i, mem_q_valid_i, mem_q_is_rd_write_i,
     mem_q_is_jump_i, mem_q_is_branch_i, mem_q_branch_predict_i, mem_q_jump_taken_i,
     mem_q_trap_valid_i, mem_done_i} = '0;
  endtask

  task automatic load_stimulus();
    stim[0]  = '{32'h0000_1000, SZ_B,  7'b0100000, 2'd0};
    stim[1]  = '{32'h0000_1001, SZ_B,  7'b0100000, 2'd0};
    stim[2]  = '{32'h0000_1002, SZ_B,  7'b0100000, 2'd0};
    stim[3]  = '{32'h0000_1003, SZ_B,  7'b0100000, 2'd0};
    stim[4]  = '{32'h0000_1000, SZ_H,  7'b0100000, 2'd0};
    stim[5]  = '{32'h0000_1002, SZ_H,  7'b0100000, 2'd0};
    stim[6]  = '{32'h0000_1000, SZ_W,  7'b0100000, 2'd0};
    stim[7]  = '{32'h0000_2003, SZ_B,  7'b1000000, 2'd0};
    stim[8]  = '{32'h0000_2001, SZ_BU, 7'b1000000, 2'd0};
    stim[9]  = '{32'h0000_2002, SZ_H,  7'b1000000, 2'd0};
    stim[10] = '{32'h0000_2000, SZ_HU, 7'b1000000, 2'd0};
    stim[11] = '{32'h0000_2004, SZ_W,  7'b1000000, 2'd0};
    // misaligned accesses
    stim[12] = '{32'h0000_3001, SZ_H,  7'b0100000, 2'd1};
    stim[13] = '{32'h0000_3002, SZ_W,  7'b1000000, 2'd1};
    stim[14] = '{32'h0000_3003, SZ_HU, 7'b1000000, 2'd1};
    stim[15] = '{32'h0000_3006, SZ_W,  7'b0100000, 2'd1};
    stim[16] = '{32'h0000_3001, SZ_W,  7'b1000001, 2'd2};
    stim[17] = '{32'h0000_3003, SZ_W,  7'b0100001, 2'd2};
    // jump, branches, plain alu op
    stim[18] = '{32'h0000_0040, '0,    7'b0010000, 2'd0};
    stim[19] = '{32'h0000_0000, '0,    7'b0001100, 2'd0};
    stim[20] = '{32'h0000_0001, '0,    7'b0001010, 2'd0};
    stim[21] = '{32'h0000_0000, '0,    7'b0001110, 2'd0};
    stim[22] = '{32'h0000_0001, '0,    7'b0001000, 2'd0};
    stim[23] = '{32'h0000_1234, '0,    7'b0000100, 2'd0};
  endtask

  task automatic drive_entry(input int k);
    mem_q_pc_i          = word_t'(32'h400 + 4 * k);
    mem_q_pc_plus_4_i   = mem_q_pc_i + 32'd4;
    mem_q_alu_result_i  = stim[k].addr;
    mem_q_size_i        = stim[k].size;
    mem_q_store_wdata_i = $urandom();
    mem_rdata_i         = $urandom();
    {mem_q_is_mem_read_i, mem_q_is_mem_write_i, mem_q_is_jump_i, mem_q_is_branch_i,
     mem_q_branch_predict_i, mem_q_jump_taken_i, mem_q_trap_valid_i} = stim[k].ctl;
    mem_q_valid_i       = (k % 4) != 3;
    mem_q_is_rd_write_i = ~mem_q_is_mem_write_i & ~mem_q_is_branch_i;
    mem_q_rd_addr_i     = reg_addr_t'(k + 1);
    mem_q_trap_pc_i     = 32'h0000_0800;
    mem_q_trap_mcause_i = 32'd2;
    mem_done_i          = 1'b1;
  endtask

  // expected outputs from the currently driven inputs
  function automatic void model_outputs();
    logic [63:0] dbl;
    int          ofs;
    int          nbytes;
    logic        access;
    logic        misal;
    logic        uns;
    word_t       lw;
    ofs    = mem_q_alu_result_i[1:0];
    nbytes = mem_q_size_i[4] ? 4 : ((mem_q_size_i[3] | mem_q_size_i[2]) ? 2 : 1);
    access = mem_q_is_mem_read_i | mem_q_is_mem_write_i;
    misal  = (nbytes == 2 && mem_q_alu_result_i[0]) || (nbytes == 4 && ofs != 0);
    exp_req = access & ~misal;
    // store data rotated up by the byte offset
    dbl = {mem_q_store_wdata_i, mem_q_store_wdata_i} << (8 * ofs);
    exp_wdata = mem_q_is_mem_write_i ? dbl[63:32] : '0;
    for (int i = 0; i < `MEM_LANES; i++)
      exp_strb[i] = access && (i >= ofs) && (i < ofs + nbytes);
    dbl = {mem_rdata_i, mem_rdata_i} >> (8 * ofs);
    lw  = dbl[31:0];
    uns = mem_q_size_i[3] | mem_q_size_i[1];
    if (nbytes == 1)
      lw = {{24{~uns & lw[7]}}, lw[7:0]};
    else if (nbytes == 2)
      lw = {{16{~uns & lw[15]}}, lw[15:0]};
    if (mem_q_is_jump_i)
      exp_rd_wdata = mem_q_pc_plus_4_i;
    else if (mem_q_is_mem_read_i)
      exp_rd_wdata = lw;
    else
      exp_rd_wdata = mem_q_alu_result_i;
    exp_rd_write = mem_q_is_rd_write_i & ~(mem_q_is_mem_read_i & misal);
    exp_trap_valid  = 1'b1;
    exp_trap_pc     = mem_q_pc_i;
    exp_trap_mcause = '0;
    if (mem_q_trap_valid_i)
    begin
      exp_trap_pc     = mem_q_trap_pc_i;
      exp_trap_mcause = mem_q_trap_mcause_i;
    end
    else if (mem_q_is_mem_write_i && misal)
      exp_trap_mcause = `TRAP_STORE_MISALIGNED;
    else if (mem_q_is_mem_read_i && misal)
      exp_trap_mcause = `TRAP_LOAD_MISALIGNED;
    else
    begin
      exp_trap_valid = 1'b0;
      exp_trap_pc    = '0;
    end
    exp_bt  = mem_q_is_branch_i & mem_q_branch_predict_i & ~mem_q_jump_taken_i;
    exp_bnt = mem_q_is_branch_i & ~mem_q_branch_predict_i & mem_q_jump_taken_i;
  endfunction

  task automatic check_entry(input int k);
    model_outputs();
    check_value("mem_addr_o", mem_addr_o, mem_q_alu_result_i);
    check_value("mem_req_o", mem_req_o, exp_req);
    check_value("mem_wen_o", mem_wen_o, mem_q_is_mem_write_i);
    check_value("mem_valid_o", mem_valid_o, 1'b0);
    check_value("mem_wdata_o", mem_wdata_o, exp_wdata);
    check_value("mem_strb_o", mem_strb_o, exp_strb);
    check_value("mem_d_valid_o", mem_d_valid_o, mem_q_valid_i);
    check_value("mem_d_rd_addr_o", mem_d_rd_addr_o, mem_q_rd_addr_i);
    check_value("mem_d_pc_plus_4_o", mem_d_pc_plus_4_o, mem_q_pc_plus_4_i);
    check_value("mem_d_rd_wdata_o", mem_d_rd_wdata_o, exp_rd_wdata);
    check_value("mem_d_is_rd_write_o", mem_d_is_rd_write_o, exp_rd_write);
    check_value("mem_d_trap_valid_o", mem_d_trap_valid_o, stim[k].cls != 2'd0);
    check_value("mem_d_trap_valid_o", mem_d_trap_valid_o, exp_trap_valid);
    check_value("mem_d_trap_pc_o", mem_d_trap_pc_o, exp_trap_pc);
    check_value("mem_d_trap_mcause_o", mem_d_trap_mcause_o, exp_trap_mcause);
    check_value("mem_btaken_mispredict_o", mem_btaken_mispredict_o, exp_bt);
    check_value("mem_bntaken_mispredict_o", mem_bntaken_mispredict_o, exp_bnt);
    check_value("mem_branch_mispredict_o", mem_branch_mispredict_o, exp_bt | exp_bnt);
  endtask

  task automatic wait_for_start_pulse();
    int cycles;
    cycles = 0;
    #1;
    while (mem_valid_o !== 1'b1)
    begin
      if (cycles == 20)
        stop_with_failure("timeout waiting for the mem_valid_o start pulse");
      @(negedge clk_i);
      #1;
      cycles++;
    end
  endtask

  task automatic drive_word_load();
    mem_q_alu_result_i  = 32'h0000_0100;
    mem_q_size_i        = SZ_W;
    mem_q_is_mem_read_i = 1'b1;
    mem_done_i          = 1'b0;
  endtask

  //**************************************************************************
  // start pulse sequence
  //**************************************************************************

  task automatic check_start_pulse();
    @(negedge clk_i);
    drive_idle();
    drive_word_load();
    wait_for_start_pulse();
    // request held while memory is still busy
    repeat (2)
    begin
      @(negedge clk_i);
      #1;
      check_value("mem_req_o", mem_req_o, 1'b1);
      check_value("mem_valid_o", mem_valid_o, 1'b0);
    end
    @(negedge clk_i);
    mem_done_i = 1'b1;
    #1;
    check_value("mem_valid_o", mem_valid_o, 1'b0);
    @(negedge clk_i);
    drive_idle();
    #1;
    check_value("mem_req_o", mem_req_o, 1'b0);
    @(negedge clk_i);
    drive_word_load();
    wait_for_start_pulse();
    @(negedge clk_i);
    mem_done_i = 1'b1;
  endtask

  initial
  begin
    void'($urandom(26));
    drive_idle();
    rst_n_i = 1'b0;
    load_stimulus();
    repeat (16) @(posedge clk_i);
    @(negedge clk_i);
    rst_n_i = 1'b1;
    #1;
    check_value("mem_valid_o", mem_valid_o, 1'b0);
    for (int k = 0; k < N_ENTRIES; k++)
    begin
      @(negedge clk_i);
      drive_entry(k);
      #1;
      check_entry(k);
    end
    check_start_pulse();
    @(negedge clk_i);
    if (u_mem_stage.u_checker.fail_cnt != 0)
      stop_with_failure("a concurrent assertion in mem_stage_checker failed");
    else
    begin
      $display("STATUS: PASS");
      $finish;
    end
  end

endmodule

// File: sources.f
+incdir+src
src/mem_pkg.sv
src/lane_if.sv
src/mem_access_ctrl.sv
src/mem_byte_lane.sv
src/mem_writeback_mux.sv
src/mem_stage.sv
tests/mem_stage_checker.sv
tests/mem_stage_tb.sv
